/* ice_bus_controller.f */
logic/ice_pkg.sv
logic/priority_select.sv
logic/ice_rx_parser.sv
logic/ice_tx_reader.sv
logic/ice_tx_merge.sv
logic/ice_bus_controller.sv
tests/ice_bus_controller_chk.sv
tests/ice_bus_controller_tb.sv

/* logic/ice_bus_controller.sv */
`timescale 1ns/1ns

module ice_bus_controller
	import ice_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	// Receive link
	input  logic [CHAR_W-1:0]  rx_char,
	input  logic               rx_char_valid,
	// Transmit link
	output logic [CHAR_W-1:0]  tx_char,
	output logic               tx_char_valid,
	input  logic               tx_char_ready,
	// Master bus
	output logic [CHAR_W-1:0]  ma_addr,
	output logic [CHAR_W-1:0]  ma_data,
	output logic               ma_data_valid,
	output logic               ma_frame_valid,
	input  logic               sl_overflow,
	// Device buffers
	input  logic [NUM_DEV-1:0] sl_arb_request,
	output logic [NUM_DEV-1:0] sl_arb_grant,
	input  logic [BUF_AW-1:0]  sl_tail,
	input  logic [BUF_DW-1:0]  sl_data,
	output logic [BUF_AW-1:0]  sl_addr,
	output logic               sl_latch_tail
);

	logic              nak_req;
	logic [CHAR_W-1:0] nak_evt_id;
	logic [CHAR_W-1:0] rd_char;
	logic              rd_char_valid;
	logic              rd_take;
	logic              start_ok;

	ice_rx_parser u_rx_parser (
		.clk            (clk),
		.rst            (rst),
		.rx_char        (rx_char),
		.rx_char_valid  (rx_char_valid),
		.sl_overflow    (sl_overflow),
		.ma_addr        (ma_addr),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.nak_req        (nak_req),
		.nak_evt_id     (nak_evt_id)
	);

	ice_tx_reader u_tx_reader (
		.clk            (clk),
		.rst            (rst),
		.sl_arb_request (sl_arb_request),
		.sl_tail        (sl_tail),
		.sl_data        (sl_data),
		.rd_take        (rd_take),
		.start_ok       (start_ok),
		.sl_arb_grant   (sl_arb_grant),
		.sl_addr        (sl_addr),
		.sl_latch_tail  (sl_latch_tail),
		.rd_char        (rd_char),
		.rd_char_valid  (rd_char_valid)
	);

	// NAK frames and reader frames share the transmit port
	ice_tx_merge u_tx_merge (
		.clk           (clk),
		.rst           (rst),
		.nak_req       (nak_req),
		.nak_evt_id    (nak_evt_id),
		.rd_char       (rd_char),
		.rd_char_valid (rd_char_valid),
		.tx_char_ready (tx_char_ready),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.rd_take       (rd_take),
		.start_ok      (start_ok)
	);

endmodule

/* logic/ice_pkg.sv */
package ice_pkg;

	// Bus devices that can hold response frames
	localparam int NUM_DEV = 2;

	// Width of one link character
	localparam int CHAR_W = 8;

	// Device buffer address width
	localparam int BUF_AW = 9;

	// Device buffer entry width
	// Top bit flags the last entry of a frame
	localparam int BUF_DW = 9;

	// First character of an immediate NAK frame
	localparam logic [CHAR_W-1:0] NAK_CHAR = 8'h15;

	// Address and event id precede the length character
	localparam int RX_HDR_LEN = 2;

endpackage

/* logic/ice_rx_parser.sv */
`timescale 1ns/1ns

module ice_rx_parser
	import ice_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [CHAR_W-1:0] rx_char,
	input  logic              rx_char_valid,
	input  logic              sl_overflow,
	output logic [CHAR_W-1:0] ma_addr,
	output logic [CHAR_W-1:0] ma_data,
	output logic              ma_data_valid,
	output logic              ma_frame_valid,
	output logic              nak_req,
	output logic [CHAR_W-1:0] nak_evt_id
);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_EVT,
		RX_LEN,
		RX_PAYLOAD,
		RX_DISCARD
	} rx_state_t;

	rx_state_t state;
	rx_state_t next_state;
	logic [CHAR_W-1:0] evt_id;
	logic [CHAR_W-1:0] pyld_len;
	logic [CHAR_W-1:0] pyld_cnt;
	logic in_payload;
	logic last_char;

	// Master bus data is the raw receive character
	assign ma_data = rx_char;
	assign ma_frame_valid = rx_char_valid;
	assign ma_data_valid = rx_char_valid &&
		(state == RX_EVT || state == RX_LEN || state == RX_PAYLOAD);
	assign nak_evt_id = evt_id;

	assign in_payload = (state == RX_PAYLOAD) || (state == RX_DISCARD);
	// Character now on rx_char closes the payload
	assign last_char = (pyld_cnt + 1'b1 == pyld_len);

	always_comb begin
		next_state = state;
		case (state)
			RX_IDLE: begin
				if (rx_char_valid)
					next_state = RX_EVT;
			end
			RX_EVT: begin
				if (rx_char_valid)
					next_state = RX_LEN;
			end
			RX_LEN: begin
				// Zero length ends the frame right here
				if (rx_char_valid)
					next_state = (rx_char == '0) ? RX_IDLE : RX_PAYLOAD;
			end
			RX_PAYLOAD: begin
				if (rx_char_valid && last_char)
					next_state = RX_IDLE;
				else if (sl_overflow)
					next_state = RX_DISCARD;
			end
			RX_DISCARD: begin
				// Swallow the rest of the payload
				if (rx_char_valid && last_char)
					next_state = RX_IDLE;
			end
			default: begin
				next_state = RX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_IDLE;
			pyld_cnt <= '0;
			nak_req <= 1'b0;
		end else begin
			state <= next_state;
			// One NAK per overflowed frame, a cycle after the device flags it
			nak_req <= (state == RX_PAYLOAD) && sl_overflow;
			if (state == RX_LEN)
				pyld_cnt <= '0;
			else if (rx_char_valid && in_payload)
				pyld_cnt <= pyld_cnt + 1'b1;
		end
	end

	// Header fields of the frame in flight
	always_ff @(posedge clk) begin
		if (rx_char_valid) begin
			case (state)
				RX_IDLE:
					ma_addr <= rx_char;
				RX_EVT:
					evt_id <= rx_char;
				RX_LEN:
					pyld_len <= rx_char;
				default: begin
				end
			endcase
		end
	end

endmodule

/* logic/ice_tx_merge.sv */
`timescale 1ns/1ns

module ice_tx_merge
	import ice_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              nak_req,
	input  logic [CHAR_W-1:0] nak_evt_id,
	input  logic [CHAR_W-1:0] rd_char,
	input  logic              rd_char_valid,
	input  logic              tx_char_ready,
	output logic [CHAR_W-1:0] tx_char,
	output logic              tx_char_valid,
	output logic              rd_take,
	output logic              start_ok
);

	logic nak_pend;
	logic nak_second;
	logic nak_first;
	logic in_frame;
	logic [CHAR_W-1:0] nak_id;
	logic [CHAR_W-1:0] send_id;

	// NAK may only start between reader frames
	assign nak_first = nak_pend && !in_frame && !nak_second;
	assign start_ok = !nak_pend && !nak_second;

	always_comb begin
		if (nak_second)
			tx_char = send_id;
		else if (nak_first)
			tx_char = NAK_CHAR;
		else
			tx_char = rd_char;
	end

	// Push only while the link is ready
	assign tx_char_valid = tx_char_ready && (nak_first || nak_second || rd_char_valid);
	assign rd_take = tx_char_ready && rd_char_valid && !nak_first && !nak_second;

	always_ff @(posedge clk) begin
		if (rst) begin
			nak_pend <= 1'b0;
			nak_second <= 1'b0;
			in_frame <= 1'b0;
		end else begin
			if (nak_req)
				nak_pend <= 1'b1;
			else if (nak_first && tx_char_ready)
				nak_pend <= 1'b0;
			if (nak_first && tx_char_ready)
				nak_second <= 1'b1;
			else if (nak_second && tx_char_ready)
				nak_second <= 1'b0;
			// Reader keeps valid high through a whole frame
			if (!rd_char_valid)
				in_frame <= 1'b0;
			else if (rd_take)
				in_frame <= 1'b1;
		end
	end

	// A later overflow overwrites the pending id, not the one on the wire
	always_ff @(posedge clk) begin
		if (nak_req)
			nak_id <= nak_evt_id;
		if (nak_first && tx_char_ready)
			send_id <= nak_id;
	end

endmodule

/* logic/ice_tx_reader.sv */
`timescale 1ns/1ns

module ice_tx_reader
	import ice_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [NUM_DEV-1:0] sl_arb_request,
	input  logic [BUF_AW-1:0]  sl_tail,
	input  logic [BUF_DW-1:0]  sl_data,
	input  logic               rd_take,
	input  logic               start_ok,
	output logic [NUM_DEV-1:0] sl_arb_grant,
	output logic [BUF_AW-1:0]  sl_addr,
	output logic               sl_latch_tail,
	output logic [CHAR_W-1:0]  rd_char,
	output logic               rd_char_valid
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_SCAN,
		TX_FETCH,
		TX_HDR,
		TX_BODY
	} tx_state_t;

	tx_state_t state;
	logic granted;
	logic frame_done;
	logic last_entry;
	logic hdr_last;
	logic [BUF_AW-1:0] offset;
	logic [BUF_AW-1:0] end_off;
	logic [BUF_AW-1:0] pyld_cnt;
	logic [CHAR_W-1:0] char_q;

	priority_select u_arb (
		.clk           (clk),
		.rst           (rst),
		.requests      (sl_arb_request),
		.release_grant (frame_done),
		.grants        (sl_arb_grant),
		.granted       (granted)
	);

	// Buffer address runs relative to the granted device's tail
	assign sl_addr = sl_tail + offset;

	assign last_entry = sl_data[BUF_DW-1];
	// Entries past the header are the payload
	assign pyld_cnt = end_off - BUF_AW'(RX_HDR_LEN);
	// Last header character is on offer once offset reaches the length slot
	assign hdr_last = (offset == BUF_AW'(RX_HDR_LEN));

	assign rd_char = char_q;
	assign rd_char_valid = (state == TX_HDR) || (state == TX_BODY);

	// When the last character leaves, offset already sits one past the frame
	assign frame_done = (state == TX_BODY) && rd_take && (offset == end_off);
	assign sl_latch_tail = frame_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			offset <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					offset <= '0;
					if (granted && start_ok)
						state <= TX_SCAN;
				end
				TX_SCAN: begin
					// One entry per cycle until the end mark
					if (last_entry) begin
						offset <= '0;
						state <= TX_FETCH;
					end else begin
						offset <= offset + 1'b1;
					end
				end
				TX_FETCH: begin
					offset <= offset + 1'b1;
					state <= TX_HDR;
				end
				TX_HDR: begin
					if (rd_take) begin
						if (hdr_last)
							state <= TX_BODY;
						else
							offset <= offset + 1'b1;
					end
				end
				TX_BODY: begin
					if (rd_take) begin
						if (offset == end_off)
							state <= TX_IDLE;
						else
							offset <= offset + 1'b1;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// Offered character is fetched one entry ahead of the send
	always_ff @(posedge clk) begin
		if (state == TX_SCAN && last_entry)
			end_off <= offset + 1'b1;
		if (state == TX_FETCH) begin
			char_q <= sl_data[CHAR_W-1:0];
		end else if (rd_take) begin
			if (state == TX_HDR && hdr_last)
				char_q <= pyld_cnt[CHAR_W-1:0];
			else
				char_q <= sl_data[CHAR_W-1:0];
		end
	end

endmodule

/* logic/priority_select.sv */
`timescale 1ns/1ns

module priority_select
	import ice_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [NUM_DEV-1:0] requests,
	input  logic               release_grant,
	output logic [NUM_DEV-1:0] grants,
	output logic               granted
);

	logic [NUM_DEV-1:0] lowest;

	// Lowest-index active request
	// Two's complement isolates the lowest set bit
	assign lowest = requests & (~requests + 1'b1);

	assign granted = |grants;

	// Grant stays put until the owner lets go
	always_ff @(posedge clk) begin
		if (rst) begin
			grants <= '0;
		end else if (release_grant) begin
			grants <= '0;
		end else if (!granted) begin
			grants <= lowest;
		end
	end

endmodule

/* tests/ice_bus_controller_chk.sv */
`timescale 1ns/1ns

module ice_bus_controller_chk
	import ice_pkg::*;
(
	input logic               clk,
	input logic               rst,
	input logic               tx_char_valid,
	input logic               tx_char_ready,
	input logic [NUM_DEV-1:0] sl_arb_grant,
	input logic               ma_data_valid,
	input logic               ma_frame_valid,
	input logic               sl_latch_tail
);

	// Characters are pushed only while the link is ready
	a_tx_push: assert property (@(posedge clk) disable iff (rst)
		tx_char_valid |-> tx_char_ready)
		else $error("tx_char_valid high while tx_char_ready is low");

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(sl_arb_grant))
		else $error("sl_arb_grant has more than one bit set");

	// Data strobe only inside a frame
	a_ma_frame: assert property (@(posedge clk) disable iff (rst)
		ma_data_valid |-> ma_frame_valid)
		else $error("ma_data_valid high without ma_frame_valid");

	a_latch_pulse: assert property (@(posedge clk) disable iff (rst)
		sl_latch_tail |=> !sl_latch_tail)
		else $error("sl_latch_tail held longer than one cycle");

endmodule

bind ice_bus_controller ice_bus_controller_chk u_chk (
	.clk            (clk),
	.rst            (rst),
	.tx_char_valid  (tx_char_valid),
	.tx_char_ready  (tx_char_ready),
	.sl_arb_grant   (sl_arb_grant),
	.ma_data_valid  (ma_data_valid),
	.ma_frame_valid (ma_frame_valid),
	.sl_latch_tail  (sl_latch_tail)
);

/* tests/ice_bus_controller_tb.sv */
`timescale 1ns/1ns

module ice_bus_controller_tb
	import ice_pkg::*;
();

	typedef enum logic [1:0] {
		K_RX,
		K_RSP,
		K_GO,
		K_RX_MID
	} step_kind_t;

	typedef struct packed {
		step_kind_t kind;
		logic [7:0] dev;
		logic [7:0] addr;
		logic [7:0] evt;
		logic [7:0] len;
		logic [7:0] ovf;
	} step_t;

	localparam int NUM_STEPS = 13;
	localparam int WAIT_LIMIT = 4000;
	localparam logic [7:0] NO_OVF = 8'hFF;

	// Receive frames, device responses and bus phases in the order they are applied
	// Device 0 responses come ahead of device 1 within a group
	step_t steps [NUM_STEPS] = '{
		'{K_RX, 8'd0, 8'h31, 8'h01, 8'd5, NO_OVF},
		'{K_RX, 8'd0, 8'h32, 8'h02, 8'd0, NO_OVF},
		'{K_RX, 8'd0, 8'h33, 8'h03, 8'd3, NO_OVF},
		'{K_RX, 8'd0, 8'h34, 8'h04, 8'd6, 8'd2},
		'{K_RX, 8'd0, 8'h35, 8'h05, 8'd4, NO_OVF},
		'{K_RX, 8'd0, 8'h36, 8'h06, 8'd3, 8'd0},
		'{K_RSP, 8'd0, 8'h40, 8'h11, 8'd3, NO_OVF},
		'{K_RSP, 8'd0, 8'h41, 8'h12, 8'd1, NO_OVF},
		'{K_RSP, 8'd1, 8'h50, 8'h13, 8'd4, NO_OVF},
		'{K_GO, 8'd0, 8'h00, 8'h00, 8'd0, NO_OVF},
		'{K_RSP, 8'd1, 8'h51, 8'h14, 8'd40, NO_OVF},
		'{K_RX_MID, 8'd0, 8'h37, 8'h07, 8'd5, 8'd1},
		'{K_RX, 8'd0, 8'h38, 8'h08, 8'd2, NO_OVF}
	};

	logic clk = 1'b0;
	logic rst;
	logic [CHAR_W-1:0] rx_char;
	logic rx_char_valid;
	logic [CHAR_W-1:0] tx_char;
	logic tx_char_valid;
	logic tx_char_ready = 1'b0;
	logic [CHAR_W-1:0] ma_addr;
	logic [CHAR_W-1:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic sl_overflow;
	logic [NUM_DEV-1:0] sl_arb_request;
	logic [NUM_DEV-1:0] sl_arb_grant;
	logic [BUF_AW-1:0] sl_tail;
	logic [BUF_DW-1:0] sl_data;
	logic [BUF_AW-1:0] sl_addr;
	logic sl_latch_tail;

	// Device buffer models with one region of the array per device
	logic [BUF_DW-1:0] mem [NUM_DEV << BUF_AW];
	logic [NUM_DEV-1:0][BUF_AW-1:0] tail = '0;
	logic [NUM_DEV-1:0][BUF_AW-1:0] head;
	logic req_en;
	int grant_idx;
	logic latch_seen = 1'b0;
	int latch_dev;
	logic [BUF_AW-1:0] latch_addr;

	logic [CHAR_W-1:0] tx_exp [$];
	logic [15:0] ma_exp [$];
	int end_exp [$];
	logic [31:0] data_rng = 32'd71;
	logic [31:0] ready_rng = 32'd71;
	int checks = 0;
	int errors = 0;

	ice_bus_controller DUT (
		.clk            (clk),
		.rst            (rst),
		.rx_char        (rx_char),
		.rx_char_valid  (rx_char_valid),
		.tx_char        (tx_char),
		.tx_char_valid  (tx_char_valid),
		.tx_char_ready  (tx_char_ready),
		.ma_addr        (ma_addr),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.sl_overflow    (sl_overflow),
		.sl_arb_request (sl_arb_request),
		.sl_arb_grant   (sl_arb_grant),
		.sl_tail        (sl_tail),
		.sl_data        (sl_data),
		.sl_addr        (sl_addr),
		.sl_latch_tail  (sl_latch_tail)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		data_rng = xorshift(data_rng);
		b = data_rng[7:0];
	endtask

	task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_extra(input string what);
		errors++;
		$display("Unexpected %s at %0t ns while nothing more was expected", what, $time);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
		$display("Checks %0d, errors %0d", checks, errors);
		$display("TB FAILED");
		$finish;
	endtask

	function automatic bit traffic_pending();
		return tx_exp.size() != 0 || ma_exp.size() != 0 || end_exp.size() != 0;
	endfunction

	// Grant index and muxed device signals
	always_comb begin
		grant_idx = 0;
		for (int d = 0; d < NUM_DEV; d++)
			if (sl_arb_grant[d])
				grant_idx = d;
	end

	always_comb begin
		for (int d = 0; d < NUM_DEV; d++)
			sl_arb_request[d] = req_en && (tail[d] != head[d]);
	end

	assign sl_tail = tail[grant_idx];
	assign sl_data = mem[(grant_idx << BUF_AW) + sl_addr];

	// Device takes its new tail on the falling edge after the latch pulse
	always @(negedge clk) begin
		if (latch_seen)
			tail[latch_dev] = latch_addr;
	end

	// Link accepts on about three cycles in four
	always @(negedge clk) begin
		ready_rng = xorshift(ready_rng);
		tx_char_ready = (ready_rng[1:0] != 2'b00);
	end

	always @(posedge clk) begin : monitor
		int e;
		if (!rst) begin
			check(ma_frame_valid, rx_char_valid, "ma_frame_valid");
			if (ma_data_valid) begin
				if (ma_exp.size() == 0) begin
					report_extra("master-bus data");
				end else begin
					e = ma_exp.pop_front();
					check(ma_addr, e[15:8], "ma_addr");
					check(ma_data, e[7:0], "ma_data");
				end
			end
			if (tx_char_valid) begin
				if (tx_exp.size() == 0)
					report_extra("transmit character");
				else
					check(tx_char, tx_exp.pop_front(), "tx_char");
			end
			if (sl_latch_tail) begin
				if (end_exp.size() == 0) begin
					report_extra("tail latch");
				end else begin
					e = end_exp.pop_front();
					check(grant_idx, e >> BUF_AW, "device at tail latch");
					check(sl_addr, e % (1 << BUF_AW), "latched tail");
				end
			end
		end
		latch_seen <= !rst && sl_latch_tail;
		latch_dev <= grant_idx;
		latch_addr <= sl_addr;
	end

	task automatic drive_char(input logic [7:0] c);
		rx_char = c;
		rx_char_valid = 1'b1;
		@(negedge clk);
		rx_char_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic send_rx(input step_t st);
		logic [7:0] pay [$];
		logic [7:0] b;
		for (int i = 0; i < st.len; i++) begin
			rand_byte(b);
			pay.push_back(b);
		end
		// Address char has no data strobe
		ma_exp.push_back({st.addr, st.evt});
		ma_exp.push_back({st.addr, st.len});
		for (int i = 0; i < st.len; i++)
			if (st.ovf == NO_OVF || i < st.ovf)
				ma_exp.push_back({st.addr, pay[i]});
		if (st.ovf != NO_OVF) begin
			tx_exp.push_back(NAK_CHAR);
			tx_exp.push_back(st.evt);
		end
		drive_char(st.addr);
		drive_char(st.evt);
		drive_char(st.len);
		for (int i = 0; i < st.len; i++) begin
			if (i == st.ovf) begin
				// Device flags overflow between two payload characters
				sl_overflow = 1'b1;
				@(negedge clk);
				sl_overflow = 1'b0;
			end
			drive_char(pay[i]);
		end
	endtask

	task automatic load_rsp(input step_t st);
		logic [BUF_AW-1:0] pos;
		logic [7:0] b;
		int base;
		base = int'(st.dev) << BUF_AW;
		pos = head[st.dev];
		tx_exp.push_back(st.addr);
		tx_exp.push_back(st.evt);
		tx_exp.push_back(st.len);
		mem[base + pos] = {1'b0, st.addr};
		pos = pos + 1'b1;
		mem[base + pos] = {st.len == 0, st.evt};
		pos = pos + 1'b1;
		for (int i = 0; i < st.len; i++) begin
			rand_byte(b);
			mem[base + pos] = {i == st.len - 1, b};
			tx_exp.push_back(b);
			pos = pos + 1'b1;
		end
		head[st.dev] = pos;
		end_exp.push_back(base + pos);
	endtask

	task automatic wait_drain();
		int cnt;
		cnt = 0;
		while (traffic_pending() && cnt < WAIT_LIMIT) begin
			cnt++;
			@(negedge clk);
		end
		if (traffic_pending()) begin
			abort_on_timeout("the expected traffic to drain");
		end else begin
			@(negedge clk);
			for (int d = 0; d < NUM_DEV; d++)
				check(tail[d], head[d], $sformatf("tail of device %0d", d));
		end
	endtask

	task automatic wait_tx_start();
		int n0;
		int cnt;
		n0 = tx_exp.size();
		cnt = 0;
		while (tx_exp.size() == n0 && cnt < WAIT_LIMIT) begin
			cnt++;
			@(negedge clk);
		end
		if (tx_exp.size() == n0)
			abort_on_timeout("a response frame to start");
	endtask

	task automatic apply_step(input step_t st);
		case (st.kind)
			K_RX: begin
				send_rx(st);
				wait_drain();
			end
			K_RSP: begin
				load_rsp(st);
			end
			K_GO: begin
				req_en = 1'b1;
				wait_drain();
				req_en = 1'b0;
			end
			K_RX_MID: begin
				// Overflow raised while a response frame is on the wire
				req_en = 1'b1;
				wait_tx_start();
				send_rx(st);
				wait_drain();
				req_en = 1'b0;
			end
			default: begin
			end
		endcase
	endtask

	initial begin
		rst = 1'b1;
		rx_char = '0;
		rx_char_valid = 1'b0;
		sl_overflow = 1'b0;
		req_en = 1'b0;
		head = '0;
		for (int i = 0; i < (NUM_DEV << BUF_AW); i++)
			mem[i] = {1'b0, 8'((i * 37) ^ (i >> 4))};
		repeat (2) @(negedge clk);
		rst = 1'b0;
		for (int s = 0; s < NUM_STEPS; s++)
			apply_step(steps[s]);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
